//--- common/memPkg.sv
package memPkg;

    // instruction and data word width, fixed by the four byte lanes
    localparam int DataWidth = 32;

    // byte counts carried on dataLen
    localparam logic [2:0] lenByte = 3'd1;
    localparam logic [2:0] lenHalf = 3'd2;
    localparam logic [2:0] lenWord = 3'd4;

    // current holder of the RAM port
    typedef enum logic [1:0] {
        ownNone  = 2'd0,
        ownData  = 2'd1,
        ownFetch = 2'd2
    } owner_t;

    // one data word, seen whole or as byte lanes
    // lane 0 is the byte at the lowest address (little-endian)
    typedef union packed {
        logic [DataWidth-1:0] word;
        logic [3:0][7:0]      lane;
    } memWord_t;

endpackage

//--- memCtrl/fetchSequencer.sv
`timescale 1ns/1ps

module fetchSequencer #(
    parameter int AddrWidth = 32
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         grant,
    input  logic                         advance,
    input  logic [AddrWidth-1:0]         fetchAddr,
    input  logic [7:0]                   ramRdata,
    output logic [AddrWidth-1:0]         seqAddr,
    output logic                         done,
    output logic [memPkg::DataWidth-1:0] fetchInst
);

    logic [2:0]       stepCnt;
    logic             stepping;
    memPkg::memWord_t capWord;
    memPkg::memWord_t instWord;

    assign stepping = grant && advance;

    // steps 0..3 present byte addresses, step 4 sees the last byte come back
    assign done = stepping && (stepCnt == 3'd4);

    assign seqAddr = fetchAddr + AddrWidth'(stepCnt);

    always_ff @(posedge clk) begin
        if (rst) begin
            stepCnt <= 3'd0;
        end else if (stepping) begin
            if (done) begin
                stepCnt <= 3'd0;
            end else begin
                stepCnt <= stepCnt + 3'd1;
            end
        end
    end

    // byte k returns one step after its address, so it lands at step k+1
    always_ff @(posedge clk) begin
        if (stepping && (stepCnt != 3'd0) && !done) begin
            capWord.lane[stepCnt[1:0] - 2'd1] <= ramRdata;
        end
    end

    // top byte is taken live from the RAM in the done cycle
    always_comb begin
        instWord         = capWord;
        instWord.lane[3] = ramRdata;
    end

    assign fetchInst = instWord.word;

endmodule

//--- memCtrl/loadStoreSequencer.sv
`timescale 1ns/1ps

module loadStoreSequencer #(
    parameter int AddrWidth = 32
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         grant,
    input  logic                         advance,
    input  logic                         dataStore,
    input  logic [2:0]                   dataLen,
    input  logic [AddrWidth-1:0]         dataAddr,
    input  logic [memPkg::DataWidth-1:0] dataWdata,
    input  logic [7:0]                   ramRdata,
    output logic [AddrWidth-1:0]         seqAddr,
    output logic                         seqWrite,
    output logic [7:0]                   seqWdata,
    output logic                         done,
    output logic [memPkg::DataWidth-1:0] dataRdata
);

    logic [2:0]       stepCnt;
    logic             stepping;
    logic             lastStep;
    memPkg::memWord_t capWord;
    memPkg::memWord_t loadWord;
    memPkg::memWord_t storeWord;

    assign stepping = grant && advance;

    // a store finishes with its last write, a load one step later
    // when the last byte is back
    assign lastStep = dataStore ? (stepCnt == dataLen - 3'd1) : (stepCnt == dataLen);
    assign done     = stepping && lastStep;

    assign seqAddr = dataAddr + AddrWidth'(stepCnt);

    always_ff @(posedge clk) begin
        if (rst) begin
            stepCnt <= 3'd0;
        end else if (stepping) begin
            if (done) begin
                stepCnt <= 3'd0;
            end else begin
                stepCnt <= stepCnt + 3'd1;
            end
        end
    end

    // load bytes arrive one step behind their address
    always_ff @(posedge clk) begin
        if (stepping && !dataStore && (stepCnt != 3'd0) && !done) begin
            capWord.lane[stepCnt[1:0] - 2'd1] <= ramRdata;
        end
    end

    // zero-extended result, top used lane comes straight from ramRdata
    always_comb begin
        loadWord.word = '0;
        case (dataLen)
            memPkg::lenByte: begin
                loadWord.lane[0] = ramRdata;
            end
            memPkg::lenHalf: begin
                loadWord.lane[0] = capWord.lane[0];
                loadWord.lane[1] = ramRdata;
            end
            memPkg::lenWord: begin
                loadWord         = capWord;
                loadWord.lane[3] = ramRdata;
            end
            default: begin
                loadWord.word = '0;
            end
        endcase
    end

    assign dataRdata = loadWord.word;

    // store lane k goes out at step k
    assign storeWord.word = dataWdata;
    assign seqWdata       = storeWord.lane[stepCnt[1:0]];
    assign seqWrite       = grant && dataStore;

endmodule

//--- memCtrl/portArbiter.sv
`timescale 1ns/1ps

module portArbiter #(
    parameter int AddrWidth = 32
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 rdy,
    input  logic                 ioFull,
    input  logic                 fetchEn,
    input  logic                 dataEn,
    input  logic [AddrWidth-1:0] fetchSeqAddr,
    input  logic [AddrWidth-1:0] dataSeqAddr,
    input  logic                 dataSeqWrite,
    input  logic [7:0]           dataSeqWdata,
    input  logic                 fetchDone,
    input  logic                 dataDone,
    output logic                 grantFetch,
    output logic                 grantData,
    output logic                 advance,
    output memPkg::owner_t       memOwner,
    output logic [AddrWidth-1:0] ramAddr,
    output logic                 ramWrite,
    output logic [7:0]           ramWdata
);

    memPkg::owner_t ownerReg;
    memPkg::owner_t activeOwner;
    logic           ownerDone;

    // whole controller freezes on cpu not ready or full io buffer
    assign advance = rdy && !ioFull;

    // a free port is granted in the same cycle, data first
    always_comb begin
        if (ownerReg != memPkg::ownNone) begin
            activeOwner = ownerReg;
        end else if (dataEn) begin
            activeOwner = memPkg::ownData;
        end else if (fetchEn) begin
            activeOwner = memPkg::ownFetch;
        end else begin
            activeOwner = memPkg::ownNone;
        end
    end

    assign grantData  = (activeOwner == memPkg::ownData);
    assign grantFetch = (activeOwner == memPkg::ownFetch);
    assign memOwner   = activeOwner;

    assign ownerDone = (grantData && dataDone) || (grantFetch && fetchDone);

    // also covers a one-byte store that is done in its grant cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            ownerReg <= memPkg::ownNone;
        end else if (advance) begin
            if (ownerDone) begin
                ownerReg <= memPkg::ownNone;
            end else begin
                ownerReg <= activeOwner;
            end
        end
    end

    always_comb begin
        case (activeOwner)
            memPkg::ownFetch: begin
                ramAddr  = fetchSeqAddr;
                ramWrite = 1'b0;
                ramWdata = 8'h00;
            end
            memPkg::ownData: begin
                ramAddr  = dataSeqAddr;
                ramWrite = advance && dataSeqWrite;
                ramWdata = dataSeqWdata;
            end
            default: begin
                ramAddr  = '0;
                ramWrite = 1'b0;
                ramWdata = 8'h00;
            end
        endcase
    end

endmodule

//--- logic/memCtrl.sv
`timescale 1ns/1ps

module memCtrl #(
    parameter int AddrWidth = 32
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         rdy,
    input  logic                         ioFull,
    input  logic                         fetchEn,
    input  logic [AddrWidth-1:0]         fetchAddr,
    input  logic                         dataEn,
    input  logic                         dataStore,
    input  logic [2:0]                   dataLen,
    input  logic [AddrWidth-1:0]         dataAddr,
    input  logic [memPkg::DataWidth-1:0] dataWdata,
    input  logic [7:0]                   ramRdata,
    output logic                         fetchDone,
    output logic [memPkg::DataWidth-1:0] fetchInst,
    output logic                         dataDone,
    output logic [memPkg::DataWidth-1:0] dataRdata,
    output memPkg::owner_t               memOwner,
    output logic [AddrWidth-1:0]         ramAddr,
    output logic                         ramWrite,
    output logic [7:0]                   ramWdata
);

    logic                 grantFetch;
    logic                 grantData;
    logic                 advance;
    logic [AddrWidth-1:0] fetchSeqAddr;
    logic [AddrWidth-1:0] dataSeqAddr;
    logic                 dataSeqWrite;
    logic [7:0]           dataSeqWdata;

    fetchSequencer #(
        .AddrWidth (AddrWidth)
    ) fetchSeq (
        .clk       (clk),
        .rst       (rst),
        .grant     (grantFetch),
        .advance   (advance),
        .fetchAddr (fetchAddr),
        .ramRdata  (ramRdata),
        .seqAddr   (fetchSeqAddr),
        .done      (fetchDone),
        .fetchInst (fetchInst)
    );

    loadStoreSequencer #(
        .AddrWidth (AddrWidth)
    ) lsSeq (
        .clk       (clk),
        .rst       (rst),
        .grant     (grantData),
        .advance   (advance),
        .dataStore (dataStore),
        .dataLen   (dataLen),
        .dataAddr  (dataAddr),
        .dataWdata (dataWdata),
        .ramRdata  (ramRdata),
        .seqAddr   (dataSeqAddr),
        .seqWrite  (dataSeqWrite),
        .seqWdata  (dataSeqWdata),
        .done      (dataDone),
        .dataRdata (dataRdata)
    );

    portArbiter #(
        .AddrWidth (AddrWidth)
    ) arb (
        .clk          (clk),
        .rst          (rst),
        .rdy          (rdy),
        .ioFull       (ioFull),
        .fetchEn      (fetchEn),
        .dataEn       (dataEn),
        .fetchSeqAddr (fetchSeqAddr),
        .dataSeqAddr  (dataSeqAddr),
        .dataSeqWrite (dataSeqWrite),
        .dataSeqWdata (dataSeqWdata),
        .fetchDone    (fetchDone),
        .dataDone     (dataDone),
        .grantFetch   (grantFetch),
        .grantData    (grantData),
        .advance      (advance),
        .memOwner     (memOwner),
        .ramAddr      (ramAddr),
        .ramWrite     (ramWrite),
        .ramWdata     (ramWdata)
    );

endmodule

//--- tests/memCtrl_assertions.sv
`timescale 1ns/1ps

module memCtrl_assertions (
    input logic           clk,
    input logic           rst,
    input logic           rdy,
    input logic           ioFull,
    input logic           advance,
    input logic           fetchDone,
    input logic           dataDone,
    input logic           ramWrite,
    input memPkg::owner_t memOwner
);

    memPkg::owner_t prevOwner;
    logic           prevFetchDone;
    logic           fetchStart;

    // owner and fetchDone as of the last advancing cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            prevOwner     <= memPkg::ownNone;
            prevFetchDone <= 1'b0;
        end else if (advance) begin
            prevOwner     <= memOwner;
            prevFetchDone <= fetchDone;
        end
    end

    // step 0 of a fetch: freshly granted, or straight after the previous fetch
    assign fetchStart = (memOwner == memPkg::ownFetch) && advance &&
                        ((prevOwner != memPkg::ownFetch) || prevFetchDone);

    resetQuiet: assert property (@(posedge clk)
        $past(rst) |-> (!fetchDone && !dataDone && !ramWrite))
        else $error("done or ramWrite high right after reset");

    noWriteInStall: assert property (@(posedge clk)
        (!rdy || ioFull) |-> !ramWrite)
        else $error("ramWrite high while rdy low or ioFull high");

    fetchDonePulse: assert property (@(posedge clk) disable iff (rst)
        fetchDone |=> !fetchDone)
        else $error("fetchDone longer than one cycle");

    dataDonePulse: assert property (@(posedge clk) disable iff (rst)
        dataDone |=> !dataDone)
        else $error("dataDone longer than one cycle");

    fetchDoneOwner: assert property (@(posedge clk) disable iff (rst)
        fetchDone |-> (memOwner != memPkg::ownData))
        else $error("fetchDone while the data unit owns the port");

    dataDoneOwner: assert property (@(posedge clk) disable iff (rst)
        dataDone |-> (memOwner != memPkg::ownFetch))
        else $error("dataDone while the fetch unit owns the port");

    // four advancing cycles after step 0 the fetch must be done
    fetchLatency: assert property (@(posedge clk) disable iff (rst)
        ($past(fetchStart, 4) && $past(advance, 3) && $past(advance, 2) &&
         $past(advance, 1) && advance) |-> fetchDone)
        else $error("unstalled fetch not done 4 cycles after its grant");

endmodule

bind memCtrl memCtrl_assertions checks (
    .clk       (clk),
    .rst       (rst),
    .rdy       (rdy),
    .ioFull    (ioFull),
    .advance   (advance),
    .fetchDone (fetchDone),
    .dataDone  (dataDone),
    .ramWrite  (ramWrite),
    .memOwner  (memOwner)
);

//--- tests/memCtrlTb.sv
`timescale 1ns/1ps

module memCtrlTb;

    localparam int AddrWidth = 32;
    localparam int ClkPeriod = 20;
    localparam int RandomTx  = 40;
    // about 60 transactions of up to 10 cycles, stalls roughly triple that, wide margin
    localparam int WatchdogCycles = 10000;

    logic                 clk;
    logic                 rst;
    logic                 rdy;
    logic                 ioFull;
    logic                 fetchEn;
    logic [AddrWidth-1:0] fetchAddr;
    logic                 dataEn;
    logic                 dataStore;
    logic [2:0]           dataLen;
    logic [AddrWidth-1:0] dataAddr;
    logic [31:0]          dataWdata;
    logic [7:0]           ramRdata = 8'h00;
    logic                 fetchDone;
    logic [31:0]          fetchInst;
    logic                 dataDone;
    logic [31:0]          dataRdata;
    memPkg::owner_t       memOwner;
    logic [AddrWidth-1:0] ramAddr;
    logic                 ramWrite;
    logic [7:0]           ramWdata;

    logic [7:0] ramModel [0:65535];
    logic [7:0] shadowRam [0:65535];
    logic       stallsOn;

    memCtrl #(
        .AddrWidth (AddrWidth)
    ) dut (
        .clk       (clk),
        .rst       (rst),
        .rdy       (rdy),
        .ioFull    (ioFull),
        .fetchEn   (fetchEn),
        .fetchAddr (fetchAddr),
        .dataEn    (dataEn),
        .dataStore (dataStore),
        .dataLen   (dataLen),
        .dataAddr  (dataAddr),
        .dataWdata (dataWdata),
        .ramRdata  (ramRdata),
        .fetchDone (fetchDone),
        .fetchInst (fetchInst),
        .dataDone  (dataDone),
        .dataRdata (dataRdata),
        .memOwner  (memOwner),
        .ramAddr   (ramAddr),
        .ramWrite  (ramWrite),
        .ramWdata  (ramWdata)
    );

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    initial begin
        for (int a = 0; a < 65536; a++) begin
            ramModel[a]  = 8'(a) ^ 8'(a >> 8) ^ 8'h5A;
            shadowRam[a] = 8'(a) ^ 8'(a >> 8) ^ 8'h5A;
        end
    end

    // byte RAM, 1-cycle read; its read register freezes together with the controller
    always @(posedge clk) begin
        if (rdy && !ioFull) begin
            ramRdata <= ramModel[ramAddr[15:0]];
            if (ramWrite) begin
                ramModel[ramAddr[15:0]] = ramWdata;
            end
        end
    end

    // random stall stretches, rdy low and/or ioFull high
    initial begin
        int stallLeft;
        int kind;
        rdy       = 1'b1;
        ioFull    = 1'b0;
        stallLeft = 0;
        forever begin
            @(posedge clk);
            #2;
            if (stallLeft > 0) begin
                stallLeft = stallLeft - 1;
            end else if (stallsOn && ($urandom_range(0, 3) == 0)) begin
                kind      = $urandom_range(0, 2);
                stallLeft = $urandom_range(0, 3);
                rdy       = (kind == 1);
                ioFull    = (kind != 0);
            end else begin
                rdy    = 1'b1;
                ioFull = 1'b0;
            end
        end
    end

    initial begin
        #(WatchdogCycles * ClkPeriod);
        stopOnError("watchdog expired, a request never completed");
    end

    always @(negedge clk) begin
        if (rst || !rdy || ioFull) begin
            assert (!fetchDone && !dataDone && !ramWrite)
                else stopOnError("done pulse or RAM write during reset or a stall");
        end
        if (rst) begin
            assert (memOwner == memPkg::ownNone)
                else stopOnError("port owned during reset");
        end
    end

    task automatic stopOnError(input string reason);
        $display("%s", reason);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic checkValue(input string testName, input logic [31:0] expected,
                              input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("** Error %s: expected %08h, actual %08h", testName, expected, actual);
            stopOnError("value mismatch");
        end
    endtask

    // little-endian bytes from the shadow copy, zero-extended
    function automatic logic [31:0] expectedBytes(input logic [31:0] addr,
                                                  input logic [2:0] len);
        logic [31:0] value;
        value = '0;
        for (int k = 0; k < int'(len); k++) begin
            value[8*k +: 8] = shadowRam[addr[15:0] + 16'(k)];
        end
        return value;
    endfunction

    function automatic void recordStore(input logic [2:0] len, input logic [31:0] addr,
                                        input logic [31:0] wdata);
        for (int k = 0; k < int'(len); k++) begin
            shadowRam[addr[15:0] + 16'(k)] = wdata[8*k +: 8];
        end
    endfunction

    function automatic logic [31:0] randomAddr();
        return $urandom_range(16, 32'h0000_FFF0);
    endfunction

    function automatic logic [2:0] randomLen();
        case ($urandom_range(0, 2))
            0: return memPkg::lenByte;
            1: return memPkg::lenHalf;
            default: return memPkg::lenWord;
        endcase
    endfunction

    task automatic fetchAt(input string testName, input logic [31:0] addr);
        logic [31:0] expected;
        logic [31:0] actual;
        expected = expectedBytes(addr, memPkg::lenWord);
        @(posedge clk);
        #2;
        fetchEn   = 1'b1;
        fetchAddr = addr;
        @(negedge clk);
        while (!fetchDone) begin
            @(negedge clk);
        end
        actual = fetchInst;
        @(posedge clk);
        #2;
        fetchEn = 1'b0;
        checkValue(testName, expected, actual);
    endtask

    task automatic dataRequest(input logic store, input logic [2:0] len,
                               input logic [31:0] addr, input logic [31:0] wdata,
                               output logic [31:0] rdata);
        @(posedge clk);
        #2;
        dataEn    = 1'b1;
        dataStore = store;
        dataLen   = len;
        dataAddr  = addr;
        dataWdata = wdata;
        @(negedge clk);
        while (!dataDone) begin
            @(negedge clk);
        end
        rdata = dataRdata;
        @(posedge clk);
        #2;
        dataEn = 1'b0;
    endtask

    // bytes around a store, so a write outside the dataLen bytes shows up
    task automatic checkRamWindow(input string testName, input logic [31:0] addr);
        logic [15:0] idx;
        for (int k = -2; k < 6; k++) begin
            idx = addr[15:0] + 16'(k);
            checkValue(testName, 32'(shadowRam[idx]), 32'(ramModel[idx]));
        end
    endtask

    task automatic loadCheck(input string testName, input logic [2:0] len,
                             input logic [31:0] addr);
        logic [31:0] expected;
        logic [31:0] actual;
        expected = expectedBytes(addr, len);
        dataRequest(1'b0, len, addr, 32'h0, actual);
        checkValue(testName, expected, actual);
    endtask

    task automatic storeCheck(input string testName, input logic [2:0] len,
                              input logic [31:0] addr, input logic [31:0] wdata);
        logic [31:0] ignored;
        dataRequest(1'b1, len, addr, wdata, ignored);
        recordStore(len, addr, wdata);
        checkRamWindow(testName, addr);
        loadCheck({testName, " readback"}, memPkg::lenWord, addr);
    endtask

    task automatic contention(input string testName, input logic store,
                              input logic [31:0] fetchAddress, input logic [31:0] dataAddress);
        logic [31:0] wdata;
        logic [31:0] expectedData;
        logic [31:0] actualData;
        time         dataEndTime;
        time         fetchEndTime;
        wdata        = $urandom();
        expectedData = expectedBytes(dataAddress, memPkg::lenWord);
        fork
            begin
                dataRequest(store, memPkg::lenWord, dataAddress, wdata, actualData);
                dataEndTime = $time;
            end
            begin
                fetchAt({testName, " fetch"}, fetchAddress);
                fetchEndTime = $time;
            end
            begin
                @(posedge clk);
                @(negedge clk);
                assert (memOwner == memPkg::ownData)
                    else stopOnError("data requester was not granted first");
            end
        join
        assert (dataEndTime < fetchEndTime)
            else stopOnError("fetchDone came before dataDone");
        if (store) begin
            recordStore(memPkg::lenWord, dataAddress, wdata);
            checkRamWindow({testName, " store"}, dataAddress);
        end else begin
            checkValue({testName, " load"}, expectedData, actualData);
        end
    endtask

    initial begin
        void'($urandom(48));
        rst       = 1'b1;
        fetchEn   = 1'b0;
        fetchAddr = '0;
        dataEn    = 1'b0;
        dataStore = 1'b0;
        dataLen   = memPkg::lenByte;
        dataAddr  = '0;
        dataWdata = '0;
        stallsOn  = 1'b0;
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;
        @(negedge clk);
        assert (!fetchDone && !dataDone && !ramWrite && memOwner == memPkg::ownNone)
            else stopOnError("outputs not idle right after reset");

        fetchAt("fetch aligned", 32'h0000_0100);
        fetchAt("fetch offset 1", 32'h0000_0201);
        fetchAt("fetch offset 3", 32'h0000_0303);
        repeat (3) fetchAt("fetch random", randomAddr());

        loadCheck("load byte", memPkg::lenByte, randomAddr());
        loadCheck("load half", memPkg::lenHalf, randomAddr());
        loadCheck("load word", memPkg::lenWord, randomAddr());

        storeCheck("store byte", memPkg::lenByte, randomAddr(), $urandom());
        storeCheck("store half", memPkg::lenHalf, randomAddr(), $urandom());
        storeCheck("store word", memPkg::lenWord, randomAddr(), $urandom());

        contention("contention load", 1'b0, 32'h0000_1000, 32'h0000_2002);
        contention("contention store", 1'b1, 32'h0000_3001, 32'h0000_3101);

        stallsOn = 1'b1;
        repeat (RandomTx) begin
            case ($urandom_range(0, 2))
                0: fetchAt("stalled fetch", randomAddr());
                1: loadCheck("stalled load", randomLen(), randomAddr());
                default: storeCheck("stalled store", randomLen(), randomAddr(), $urandom());
            endcase
        end
        stallsOn = 1'b0;

        repeat (2) @(posedge clk);
        $display("=== PASS ===");
        $finish;
    end

endmodule

//--- memCtrl.f
common/memPkg.sv
memCtrl/fetchSequencer.sv
memCtrl/loadStoreSequencer.sv
memCtrl/portArbiter.sv
logic/memCtrl.sv
tests/memCtrl_assertions.sv
tests/memCtrlTb.sv

//--- run.sh
#!/usr/bin/env bash
# build the memCtrl testbench with Verilator and run it
set -u

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module memCtrlTb --Mdir "$buildDir" -o memCtrlSim \
    -f memCtrl.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit "$status"
fi

"./$buildDir/memCtrlSim"
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation ended with status $status"
    exit "$status"
fi

exit 0
